// ==== hdl/ecc_code_pkg.sv ====
`default_nettype none

package ecc_code_pkg;

    localparam int DATA_WIDTH   = 51;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [PARITY_WIDTH-1:0] syndrome_t;

    typedef struct packed {
        parity_t parity;  // Upper 7 bits
        data_t   data;
    } codeword_t;

    // Odd-weight columns, so any double error leaves an even nonzero syndrome
    localparam syndrome_t H_COLUMNS [DATA_WIDTH] = '{
        7'b1000011,  // Bit 0
        7'b1000101,
        7'b1000110,
        7'b0000111,
        7'b1001001,
        7'b1001010,
        7'b0001011,
        7'b1001100,
        7'b0001101,
        7'b0001110,
        7'b1001111,  // Bit 10
        7'b1010001,
        7'b1010010,
        7'b0010011,
        7'b1010100,
        7'b0010101,
        7'b0010110,
        7'b1010111,
        7'b1011000,
        7'b0011001,
        7'b0011010,  // Bit 20
        7'b1011011,
        7'b0011100,
        7'b1011101,
        7'b1011110,
        7'b0011111,
        7'b1100001,
        7'b1100010,
        7'b0100011,
        7'b1100100,
        7'b0100101,  // Bit 30
        7'b0100110,
        7'b1100111,
        7'b1101000,
        7'b0101001,
        7'b0101010,
        7'b1101011,
        7'b0101100,
        7'b1101101,
        7'b1101110,
        7'b0101111,  // Bit 40
        7'b1110000,
        7'b0110001,
        7'b0110010,
        7'b1110011,
        7'b0110100,
        7'b1110101,
        7'b1110110,
        7'b0110111,
        7'b0111000,
        7'b1111001   // Bit 50
    };

    // Check bit j is the XOR of every data bit whose column has bit j set
    function automatic parity_t calc_parity(input data_t data);
        parity_t parity;
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data[i]) begin
                parity = parity ^ H_COLUMNS[i];
            end
        end
        return parity;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ecc_mem_pkg.sv ====
`default_nettype none

package ecc_mem_pkg;

    localparam int DEPTH       = 16;
    localparam int ADDR_WIDTH  = $clog2(DEPTH);
    localparam int COUNT_WIDTH = 16;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // Registered write from encoder to RAM
    typedef struct packed {
        addr_t                   addr;
        ecc_code_pkg::codeword_t word;
    } wr_req_t;

    typedef struct packed {
        addr_t               addr;
        ecc_code_pkg::data_t data;
        logic                sbit_err;  // Corrected or parity-only error
        logic                dbit_err;  // Uncorrectable
    } rd_resp_t;

endpackage

`default_nettype wire

// ==== hdl/ecc_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_encoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  ecc_mem_pkg::addr_t      wr_addr,
    input  ecc_code_pkg::data_t     wr_data,
    input  ecc_code_pkg::codeword_t wr_flip,
    output logic                    wr_req_en,
    output ecc_mem_pkg::wr_req_t    wr_req
);

    ecc_code_pkg::codeword_t                clean_word;
    logic [ecc_code_pkg::CODE_WIDTH-1:0]    flipped;

    always_comb begin
        clean_word.data   = wr_data;
        clean_word.parity = ecc_code_pkg::calc_parity(wr_data);
    end

    assign flipped = clean_word ^ wr_flip;  // Error injection hook

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_req_en <= 1'b0;
        end else begin
            wr_req_en <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_req.addr <= wr_addr;
            wr_req.word <= flipped;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_codeword_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_codeword_ram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_req_en,
    input  ecc_mem_pkg::wr_req_t    wr_req,
    input  logic                    rd_en,
    input  ecc_mem_pkg::addr_t      rd_addr,
    input  logic                    bypass,
    output logic                    rd_word_en,
    output ecc_code_pkg::codeword_t rd_word,
    output ecc_mem_pkg::addr_t      rd_word_addr,
    output logic                    rd_word_bypass
);

    ecc_code_pkg::codeword_t mem [ecc_mem_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr_req_en) begin
            mem[wr_req.addr] <= wr_req.word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word_en <= 1'b0;
        end else begin
            rd_word_en <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word        <= mem[rd_addr];  // Old word on the write edge
            rd_word_addr   <= rd_addr;  // Tag travels with the data
            rd_word_bypass <= bypass;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rd_word_en,
    input  ecc_code_pkg::codeword_t rd_word,
    input  ecc_mem_pkg::addr_t      rd_word_addr,
    input  logic                    rd_word_bypass,
    output logic                    rd_valid,
    output ecc_mem_pkg::rd_resp_t   rd_resp,
    output ecc_mem_pkg::count_t     sbe_count,
    output ecc_mem_pkg::count_t     dbe_count
);

    ecc_code_pkg::syndrome_t syndrome;
    ecc_code_pkg::data_t     flip_mask;
    logic                    col_hit;
    logic                    parity_hit;
    logic                    sbit;
    logic                    dbit;
    ecc_mem_pkg::rd_resp_t   resp_next;

    function automatic ecc_mem_pkg::count_t sat_inc(
        input ecc_mem_pkg::count_t count,
        input logic                hit
    );
        if (hit && (count != '1)) begin
            return count + 1'b1;
        end
        return count;
    endfunction

    always_comb begin
        syndrome  = rd_word.parity ^ ecc_code_pkg::calc_parity(rd_word.data);
        flip_mask = '0;
        col_hit   = 1'b0;
        for (int i = 0; i < ecc_code_pkg::DATA_WIDTH; i++) begin
            if (syndrome == ecc_code_pkg::H_COLUMNS[i]) begin
                flip_mask[i] = 1'b1;
                col_hit      = 1'b1;
            end
        end
    end

    assign parity_hit = $onehot(syndrome);  // Check bit itself flipped
    assign sbit       = col_hit | parity_hit;
    assign dbit       = (syndrome != '0) & ~sbit;

    always_comb begin
        resp_next.addr = rd_word_addr;
        if (rd_word_bypass) begin
            resp_next.data     = rd_word.data;  // Raw, no flags
            resp_next.sbit_err = 1'b0;
            resp_next.dbit_err = 1'b0;
        end else begin
            resp_next.data     = rd_word.data ^ flip_mask;
            resp_next.sbit_err = sbit;
            resp_next.dbit_err = dbit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            sbe_count <= '0;
            dbe_count <= '0;
        end else begin
            rd_valid  <= rd_word_en;
            sbe_count <= sat_inc(sbe_count, rd_word_en & resp_next.sbit_err);
            dbe_count <= sat_inc(dbe_count, rd_word_en & resp_next.dbit_err);
        end
    end

    // Held until the next valid read
    always_ff @(posedge clk) begin
        if (rd_word_en) begin
            rd_resp <= resp_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  ecc_mem_pkg::addr_t      wr_addr,
    input  ecc_code_pkg::data_t     wr_data,
    input  ecc_code_pkg::codeword_t wr_flip,
    input  logic                    rd_en,
    input  ecc_mem_pkg::addr_t      rd_addr,
    input  logic                    bypass,
    output logic                    rd_valid,
    output ecc_mem_pkg::rd_resp_t   rd_resp,
    output ecc_mem_pkg::count_t     sbe_count,
    output ecc_mem_pkg::count_t     dbe_count
);

    logic                    wr_req_en;
    ecc_mem_pkg::wr_req_t    wr_req;
    logic                    rd_word_en;
    ecc_code_pkg::codeword_t rd_word;
    ecc_mem_pkg::addr_t      rd_word_addr;
    logic                    rd_word_bypass;

    ecc_encoder i_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_flip   (wr_flip),
        .wr_req_en (wr_req_en),
        .wr_req    (wr_req)
    );

    ecc_codeword_ram i_ram (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_req_en      (wr_req_en),
        .wr_req         (wr_req),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .bypass         (bypass),
        .rd_word_en     (rd_word_en),
        .rd_word        (rd_word),
        .rd_word_addr   (rd_word_addr),
        .rd_word_bypass (rd_word_bypass)
    );

    ecc_decoder i_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_word_en     (rd_word_en),
        .rd_word        (rd_word),
        .rd_word_addr   (rd_word_addr),
        .rd_word_bypass (rd_word_bypass),
        .rd_valid       (rd_valid),
        .rd_resp        (rd_resp),
        .sbe_count      (sbe_count),
        .dbe_count      (dbe_count)
    );

endmodule

`default_nettype wire

// ==== testbench/ecc_mem_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rd_en,
    input logic                  bypass,
    input logic                  rd_valid,
    input ecc_mem_pkg::rd_resp_t rd_resp
);

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> !(rd_resp.sbit_err && rd_resp.dbit_err))
        else $error("sbit_err and dbit_err set together");

    // Fixed read latency of two cycles
    a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2))
        else $error("rd_valid does not follow rd_en by 2 cycles");

    a_bypass_no_flags: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_valid && $past(rd_en && bypass, 2)) |-> !(rd_resp.sbit_err || rd_resp.dbit_err))
        else $error("Error flag set on a bypass read");

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_valid))
        else $error("rd_valid unknown after reset");

endmodule

bind ecc_mem_top ecc_mem_checker i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .bypass   (bypass),
    .rd_valid (rd_valid),
    .rd_resp  (rd_resp)
);

`default_nettype wire

// ==== testbench/ecc_mem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_WORDS  = ecc_mem_pkg::DEPTH;
    localparam int NUM_DOUBLE = 8;
    // Reads plus writes over all tests
    localparam int NUM_OPS = 2 * NUM_WORDS + 2 * ecc_code_pkg::DATA_WIDTH
                           + 2 * ecc_code_pkg::PARITY_WIDTH + 2 * NUM_DOUBLE + NUM_WORDS + 3;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    wr_en;
    ecc_mem_pkg::addr_t      wr_addr;
    ecc_code_pkg::data_t     wr_data;
    ecc_code_pkg::codeword_t wr_flip;
    logic                    rd_en;
    ecc_mem_pkg::addr_t      rd_addr;
    logic                    bypass;
    logic                    rd_valid;
    ecc_mem_pkg::rd_resp_t   rd_resp;
    ecc_mem_pkg::count_t     sbe_count;
    ecc_mem_pkg::count_t     dbe_count;

    integer                  seed = 3992;
    ecc_code_pkg::data_t     shadow_data [NUM_WORDS];
    ecc_code_pkg::codeword_t shadow_flip [NUM_WORDS];
    ecc_mem_pkg::rd_resp_t   exp_q [$];
    string                   name_q [$];
    string                   test_name = "reset";
    ecc_mem_pkg::count_t     exp_sbe = '0;
    ecc_mem_pkg::count_t     exp_dbe = '0;
    logic                    run_done = 1'b0;

    ecc_mem_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_flip   (wr_flip),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .bypass    (bypass),
        .rd_valid  (rd_valid),
        .rd_resp   (rd_resp),
        .sbe_count (sbe_count),
        .dbe_count (dbe_count)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bit j is the parity of the data bits whose column has bit j set
    function automatic ecc_code_pkg::parity_t check_bits(input ecc_code_pkg::data_t data);
        ecc_code_pkg::parity_t bits;
        bits = '0;
        for (int j = 0; j < ecc_code_pkg::PARITY_WIDTH; j++) begin
            for (int i = 0; i < ecc_code_pkg::DATA_WIDTH; i++) begin
                bits[j] = bits[j] ^ (data[i] & ecc_code_pkg::H_COLUMNS[i][j]);
            end
        end
        return bits;
    endfunction

    function automatic ecc_mem_pkg::rd_resp_t ref_resp(
        input ecc_code_pkg::data_t     data,
        input ecc_code_pkg::codeword_t flip,
        input logic                    byp
    );
        ecc_code_pkg::codeword_t stored;
        ecc_code_pkg::syndrome_t syn;
        ecc_mem_pkg::rd_resp_t   resp;
        stored.data   = data;
        stored.parity = check_bits(data);
        stored        = stored ^ flip;
        syn           = stored.parity ^ check_bits(stored.data);
        resp          = '0;
        resp.data     = stored.data;
        if (!byp && syn != '0) begin
            if ($countones(syn) == 1) begin
                resp.sbit_err = 1'b1;  // Check bit only
            end else begin
                for (int i = 0; i < ecc_code_pkg::DATA_WIDTH; i++) begin
                    if (syn == ecc_code_pkg::H_COLUMNS[i]) begin
                        resp.data[i]  = ~resp.data[i];
                        resp.sbit_err = 1'b1;
                    end
                end
                resp.dbit_err = ~resp.sbit_err;
            end
        end
        return resp;
    endfunction

    function automatic ecc_code_pkg::data_t rand_data();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[ecc_code_pkg::DATA_WIDTH-1:0];
    endfunction

    function automatic int rand_pos(input int limit);
        return int'({$random(seed)} % limit);
    endfunction

    task automatic abort_run();
        run_done = 1'b1;
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_resp(
        input string                 name,
        input ecc_mem_pkg::rd_resp_t exp,
        input ecc_mem_pkg::rd_resp_t act
    );
        string exp_str;
        string act_str;
        if (act !== exp) begin
            exp_str = $sformatf("addr=%0d data=%h sbit=%b dbit=%b",
                                exp.addr, exp.data, exp.sbit_err, exp.dbit_err);
            act_str = $sformatf("addr=%0d data=%h sbit=%b dbit=%b",
                                act.addr, act.data, act.sbit_err, act.dbit_err);
            $display("ERROR %s: expected %s, actual %s", name, exp_str, act_str);
            abort_run();
        end
    endtask

    task automatic check_count(
        input string               name,
        input ecc_mem_pkg::count_t exp,
        input ecc_mem_pkg::count_t act
    );
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            wr_en = 1'b0;
            rd_en = 1'b0;
        end
    endtask

    task automatic write_word(
        input ecc_mem_pkg::addr_t      addr,
        input ecc_code_pkg::data_t     data,
        input ecc_code_pkg::codeword_t flip
    );
        @(negedge clk);
        wr_en             = 1'b1;
        wr_addr           = addr;
        wr_data           = data;
        wr_flip           = flip;
        rd_en             = 1'b0;
        shadow_data[addr] = data;
        shadow_flip[addr] = flip;
    endtask

    task automatic read_word(input ecc_mem_pkg::addr_t addr, input logic byp);
        ecc_mem_pkg::rd_resp_t exp;
        @(negedge clk);
        wr_en   = 1'b0;
        rd_en   = 1'b1;
        rd_addr = addr;
        bypass  = byp;
        exp      = ref_resp(shadow_data[addr], shadow_flip[addr], byp);
        exp.addr = addr;
        exp_q.push_back(exp);
        name_q.push_back(test_name);
        if (exp.sbit_err && exp_sbe != '1) begin
            exp_sbe = exp_sbe + 16'd1;
        end
        if (exp.dbit_err && exp_dbe != '1) begin
            exp_dbe = exp_dbe + 16'd1;
        end
    endtask

    initial begin : stimulus
        ecc_code_pkg::codeword_t             flip;
        logic [ecc_code_pkg::CODE_WIDTH-1:0] mask;
        ecc_mem_pkg::addr_t                  addr;
        ecc_code_pkg::data_t                 old_data;
        ecc_code_pkg::data_t                 new_data;
        int                                  p1;
        int                                  p2;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_flip = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        bypass  = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_count("reset sbe_count", '0, sbe_count);
        check_count("reset dbe_count", '0, dbe_count);

        test_name = "clean";
        for (int a = 0; a < NUM_WORDS; a++) begin
            write_word(ecc_mem_pkg::addr_t'(a), rand_data(), '0);
        end
        idle_cycles(2);
        for (int a = 0; a < NUM_WORDS; a++) begin
            read_word(ecc_mem_pkg::addr_t'(a), 1'b0);  // Back to back
        end
        idle_cycles(2);

        // Read on the RAM write edge sees the old word, one edge later the new
        test_name = "write_timing";
        old_data  = shadow_data[0];
        new_data  = rand_data();
        write_word('0, new_data, '0);
        shadow_data[0] = old_data;
        read_word('0, 1'b0);
        shadow_data[0] = new_data;
        read_word('0, 1'b0);
        idle_cycles(2);

        test_name = "data_bit";
        for (int b = 0; b < ecc_code_pkg::DATA_WIDTH; b++) begin
            flip         = '0;
            flip.data[b] = 1'b1;
            addr         = ecc_mem_pkg::addr_t'(b % NUM_WORDS);
            write_word(addr, rand_data(), flip);
            idle_cycles(2);
            read_word(addr, 1'b0);
        end

        test_name = "check_bit";
        for (int j = 0; j < ecc_code_pkg::PARITY_WIDTH; j++) begin
            flip           = '0;
            flip.parity[j] = 1'b1;
            addr           = ecc_mem_pkg::addr_t'(j);
            write_word(addr, rand_data(), flip);
            idle_cycles(2);
            read_word(addr, 1'b0);
        end

        test_name = "double";
        for (int k = 0; k < NUM_DOUBLE; k++) begin
            p1       = rand_pos(ecc_code_pkg::CODE_WIDTH);
            p2       = (p1 + 1 + rand_pos(ecc_code_pkg::CODE_WIDTH - 1))
                       % ecc_code_pkg::CODE_WIDTH;
            mask     = '0;
            mask[p1] = 1'b1;
            mask[p2] = 1'b1;
            flip     = mask;
            addr     = ecc_mem_pkg::addr_t'(k);
            write_word(addr, rand_data(), flip);
            idle_cycles(2);
            read_word(addr, 1'b0);
        end

        // Low words hold double errors, high words single data errors
        test_name = "bypass";
        for (int a = 0; a < NUM_WORDS; a++) begin
            read_word(ecc_mem_pkg::addr_t'(a), 1'b1);
        end
        idle_cycles(4);

        check_count("sbe_count", exp_sbe, sbe_count);
        check_count("dbe_count", exp_dbe, dbe_count);
        run_done = 1'b1;
        if (exp_q.size() != 0) begin
            $display("%0d read responses never arrived", exp_q.size());
            $display("** FAIL **");
            $fatal(1, "Missing read responses");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // Outputs settle shortly after the rising edge
    initial begin : response_compare
        ecc_mem_pkg::rd_resp_t exp;
        string                 name;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && rd_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A read response for address %0d came with no read outstanding",
                             rd_resp.addr);
                    abort_run();
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_resp(name, exp, rd_resp);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    // Run ended before the final checks
    final begin
        if (!run_done) begin
            $display("** FAIL **");
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/ecc_code_pkg.sv
hdl/ecc_mem_pkg.sv
hdl/ecc_encoder.sv
hdl/ecc_codeword_ram.sv
hdl/ecc_decoder.sv
hdl/ecc_mem_top.sv
testbench/ecc_mem_checker.sv
testbench/ecc_mem_tb.sv

// ==== Makefile ====
TOP := ecc_mem_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
